// ==== decode_unit.f ====
+incdir+verilog
verilog/decode_pkg.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/uop_fifo.sv
verilog/branch_resolver.sv
verilog/decode_unit.sv
verification/decode_unit_sva.sv
verification/decode_unit_tb.sv

// ==== verification/decode_unit_sva.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module decode_unit_sva
(
   input wire                                      clk,
   input wire                                      rst_i,
   input wire                                      issue_ready_i,
   input wire                                      issue_valid_i,
   input wire                                      issue_redirect_i,
   input wire [4*`DU_XLEN+`DU_RADDR_W+11:0]        issue_word_i
);

   // buffer is cleared by the reset edge
   a_reset_idle: assert property (@(posedge clk) rst_i |=> !issue_valid_i)
      else $error("issue channel valid right after a reset edge");

   // stalled issue packet must not move
   a_issue_hold: assert property (@(posedge clk) disable iff (rst_i)
      issue_valid_i && !issue_ready_i |=> issue_valid_i && $stable(issue_word_i))
      else $error("issue packet changed while stalled");

   a_redirect_valid: assert property (@(posedge clk) disable iff (rst_i)
      issue_redirect_i |-> issue_valid_i)
      else $error("redirect raised without a valid issue packet");

endmodule

bind decode_unit decode_unit_sva u_sva
(
   .clk              (clk),
   .rst_i            (rst_i),
   .issue_ready_i    (issue_ready_i),
   .issue_valid_i    (issue_valid_o),
   .issue_redirect_i (issue_redirect_o),
   .issue_word_i     ({issue_pc_o, issue_op_o, issue_sel_o, issue_a_o, issue_b_o, issue_rd_o,
                       issue_wreg_o, issue_illegal_o, issue_taken_o, issue_redirect_o,
                       issue_target_o})
);

`default_nettype wire

// ==== verification/decode_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module decode_unit_tb;
   import decode_pkg::*;

   localparam int SEED     = 95;
   localparam int NUM_INST = 60;    // per directed phase
   localparam int TIMEOUT  = 200;   // cycles per wait

   typedef struct packed {
      logic [`DU_XLEN-1:0]    pc;
      alu_op_e                op;
      alu_sel_e               sel;
      logic [`DU_XLEN-1:0]    a;
      logic [`DU_XLEN-1:0]    b;
      logic [`DU_RADDR_W-1:0] rd;
      logic                   wreg;
      logic                   illegal;
      logic                   taken;
      logic                   redirect;
      logic [`DU_XLEN-1:0]    target;
   } issue_pkt_t;

   logic                   clk;
   logic                   rst_i;
   logic                   in_valid_i;
   logic [`DU_XLEN-1:0]    in_pc_i;
   logic [`DU_INST_W-1:0]  in_inst_i;
   logic                   in_pred_taken_i;
   logic                   in_ready_o;
   logic                   wb_en_i;
   logic [`DU_RADDR_W-1:0] wb_addr_i;
   logic [`DU_XLEN-1:0]    wb_data_i;
   logic                   issue_ready_i;
   logic                   issue_valid_o;
   logic [`DU_XLEN-1:0]    issue_pc_o;
   alu_op_e                issue_op_o;
   alu_sel_e               issue_sel_o;
   logic [`DU_XLEN-1:0]    issue_a_o;
   logic [`DU_XLEN-1:0]    issue_b_o;
   logic [`DU_RADDR_W-1:0] issue_rd_o;
   logic                   issue_wreg_o;
   logic                   issue_illegal_o;
   logic                   issue_taken_o;
   logic                   issue_redirect_o;
   logic [`DU_XLEN-1:0]    issue_target_o;

   logic [31:0]         lcg_state;
   logic                ready_random;   // random issue_ready_i pattern
   logic [`DU_XLEN-1:0] shadow [0:`DU_NUM_REGS-1];
   issue_pkt_t          exp_q [$];
   int                  sent;
   int                  issued;

   decode_unit dut (.*);

   always
   begin
      clk = 1'b0;
      #20;
      clk = 1'b1;
      #20;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("Error: time %0t signal %s got %h expected %h",
                             $time, name, got, exp));
   endtask

   function automatic logic [15:0] rnd16();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];
   endfunction

   function automatic logic [31:0] rnd32();
      logic [15:0] hi;
      hi = rnd16();
      return {hi, rnd16()};
   endfunction

   function automatic logic [`DU_XLEN-1:0] read_shadow(input logic [`DU_RADDR_W-1:0] addr);
      if (addr == '0)
         return '0;
      else if (wb_en_i && (wb_addr_i == addr))
         return wb_data_i;                        // same-cycle write-back
      return shadow[addr];
   endfunction

   function automatic alu_sel_e result_class(input alu_op_e op);
      case (op)
         ALU_NOP:                             return SEL_NOP;
         ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: return SEL_ARITH;
         ALU_XOR, ALU_OR, ALU_AND:            return SEL_LOGIC;
         ALU_SLL, ALU_SRL, ALU_SRA:           return SEL_SHIFT;
         default:                             return SEL_JUMP;
      endcase
   endfunction

   // ------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------
   function automatic issue_pkt_t expect_issue(input logic [31:0] pc, input logic [31:0] inst,
                                               input logic pred, input logic [31:0] r1,
                                               input logic [31:0] r2);
      issue_pkt_t  p;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [31:0] i_imm;
      logic [31:0] u_imm;
      logic [31:0] b_imm;
      logic [31:0] j_imm;
      logic        legal;
      f3    = inst[14:12];
      f7    = inst[31:25];
      i_imm = {{20{inst[31]}}, inst[31:20]};
      u_imm = {inst[31:12], 12'h000};
      b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      p     = '0;
      p.pc  = pc;
      p.rd  = inst[11:7];
      legal = 1'b1;
      case (inst[6:0])
         7'b0110011:                              // OP
         begin
            p.a    = r1;
            p.b    = r2;
            p.wreg = 1'b1;
            case ({f7, f3})
               10'b0000000_000: p.op = ALU_ADD;
               10'b0100000_000: p.op = ALU_SUB;
               10'b0000000_001: p.op = ALU_SLL;
               10'b0000000_010: p.op = ALU_SLT;
               10'b0000000_011: p.op = ALU_SLTU;
               10'b0000000_100: p.op = ALU_XOR;
               10'b0000000_101: p.op = ALU_SRL;
               10'b0100000_101: p.op = ALU_SRA;
               10'b0000000_110: p.op = ALU_OR;
               10'b0000000_111: p.op = ALU_AND;
               default:         legal = 1'b0;
            endcase
         end
         7'b0010011:                              // OP-IMM
         begin
            p.a    = r1;
            p.b    = i_imm;
            p.wreg = 1'b1;
            case (f3)
               3'b000: p.op = ALU_ADD;
               3'b010: p.op = ALU_SLT;
               3'b011: p.op = ALU_SLTU;
               3'b100: p.op = ALU_XOR;
               3'b110: p.op = ALU_OR;
               3'b111: p.op = ALU_AND;
               3'b001:
               begin
                  p.op  = ALU_SLL;
                  p.b   = {27'h0, inst[24:20]};
                  legal = (f7 == 7'h00);
               end
               default:
               begin
                  p.op  = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
                  p.b   = {27'h0, inst[24:20]};
                  legal = (f7 == 7'h00) || (f7 == 7'h20);
               end
            endcase
         end
         7'b0110111, 7'b0010111:                  // lui, auipc
         begin
            p.op   = ALU_OR;
            p.wreg = 1'b1;
            p.a    = inst[5] ? u_imm : pc + u_imm;
            p.b    = p.a;
         end
         7'b1101111, 7'b1100111:                  // jal, jalr
         begin
            p.op       = inst[3] ? ALU_JAL : ALU_JALR;
            p.a        = pc + `DU_PC_STEP;
            p.wreg     = 1'b1;
            p.taken    = 1'b1;
            p.redirect = 1'b1;
            p.target   = inst[3] ? pc + j_imm : (r1 + i_imm) & ~32'h1;
            legal      = inst[3] || (f3 == 3'b000);
         end
         7'b1100011:                              // branch
         begin
            p.a = r1;
            p.b = r2;
            case (f3)
               3'b000: p.op = ALU_BEQ;
               3'b001: p.op = ALU_BNE;
               3'b100: p.op = ALU_BLT;
               3'b101: p.op = ALU_BGE;
               3'b110: p.op = ALU_BLTU;
               3'b111: p.op = ALU_BGEU;
               default: legal = 1'b0;
            endcase
            case (f3)
               3'b000:  p.taken = (r1 == r2);
               3'b001:  p.taken = (r1 != r2);
               3'b100:  p.taken = ($signed(r1) < $signed(r2));
               3'b101:  p.taken = ($signed(r1) >= $signed(r2));
               3'b110:  p.taken = (r1 < r2);
               default: p.taken = (r1 >= r2);
            endcase
            p.redirect = (p.taken != pred);
            p.target   = p.taken ? pc + b_imm : pc + `DU_PC_STEP;
         end
         default:
            legal = 1'b0;
      endcase
      p.sel = result_class(p.op);
      if (!legal)
      begin
         p         = '0;
         p.pc      = pc;
         p.rd      = inst[11:7];
         p.illegal = 1'b1;
      end
      return p;
   endfunction

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------
   function automatic logic [31:0] make_inst(input int kind);
      logic [31:0] r;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic [11:0] imm;
      r   = rnd32();
      rs1 = {2'b00, r[7:5]};                      // few regs, x0 and rs1 == rs2 common
      rs2 = {2'b00, r[10:8]};
      f3  = r[13:11];
      imm = r[31:20];
      if ((f3 == 3'b001 || f3 == 3'b101) && !r[15])
         imm = {r[14] ? 7'h20 : 7'h00, r[24:20]};
      case (kind)
         0:       return {r[14] ? 7'h20 : 7'h00, rs2, rs1, f3, r[4:0], 7'b0110011};
         1:       return {imm, rs1, f3, r[4:0], 7'b0010011};
         2:       return {r[31:12], r[4:0], 7'b0110111};
         3:       return {r[31:12], r[4:0], 7'b0010111};
         4:       return {r[31:25], rs2, rs1, f3, r[4:0], 7'b1100011};
         5:       return {r[31:12], r[4:0], 7'b1101111};
         6:       return {r[31:20], rs1, r[15] ? 3'b000 : f3, r[4:0], 7'b1100111};
         default: return {r[31:7], r[16] ? 7'b0000011 : 7'b0100011};   // load or store
      endcase
   endfunction

   // one cycle of drive, write-back often aimed at the held instruction's sources
   task automatic tick(input logic v, input logic [31:0] inst, input logic [31:0] pc,
                       input logic pred);
      logic [31:0] r;
      r = rnd32();
      in_valid_i      <= v;
      in_inst_i       <= inst;
      in_pc_i         <= pc;
      in_pred_taken_i <= pred;
      wb_en_i         <= r[0];
      wb_addr_i       <= r[1] ? (r[2] ? inst[19:15] : inst[24:20]) : {2'b00, r[5:3]};
      wb_data_i       <= r[6] ? {30'h0, r[8:7]} : rnd32();
      issue_ready_i   <= ready_random ? (r[9] | r[10]) : 1'b1;
      @(posedge clk);
   endtask

   task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc, input logic pred);
      int waits;
      waits = 0;
      tick(1'b1, inst, pc, pred);
      while (!in_ready_o)
      begin
         waits++;
         if (waits > TIMEOUT)
            abort_run("input channel never accepted an instruction");
         tick(1'b1, inst, pc, pred);
      end
      sent++;
   endtask

   task automatic wait_drain();
      int waits;
      waits = 0;
      while (exp_q.size() != 0)
      begin
         waits++;
         if (waits > TIMEOUT)
            abort_run("issued instructions stopped before the buffer drained");
         tick(1'b0, '0, '0, 1'b0);
      end
   endtask

   task automatic run_phase(input int kind_lo, input int kind_hi, input int count,
                            input logic rdy_rand);
      logic [31:0] r;
      int          kind;
      ready_random = rdy_rand;
      for (int n = 0; n < count; n++)
      begin
         r    = rnd32();
         kind = kind_lo + int'(r[7:0]) % (kind_hi - kind_lo + 1);
         send_inst(make_inst(kind), rnd32() & ~32'h3, r[8]);
         if (r[9] && r[10])                       // gap between bursts
            repeat (int'(r[12:11]) + 1) tick(1'b0, '0, '0, 1'b0);
      end
      tick(1'b0, '0, '0, 1'b0);
      wait_drain();
   endtask

   // ------------------------------------------------------------
   // monitor and compare
   // ------------------------------------------------------------
   always @(posedge clk)
   begin
      issue_pkt_t e;
      if (rst_i)
      begin
         for (int i = 0; i < `DU_NUM_REGS; i++)
            shadow[i] = '0;
      end
      else
      begin
         check_val("in_ready_o", in_ready_o, exp_q.size() < 2);
         check_val("issue_valid_o", issue_valid_o, exp_q.size() != 0);
         if (issue_valid_o && issue_ready_i)
         begin
            e = exp_q.pop_front();
            check_val("issue_pc_o", issue_pc_o, e.pc);
            check_val("issue_op_o", issue_op_o, e.op);
            check_val("issue_sel_o", issue_sel_o, e.sel);
            check_val("issue_a_o", issue_a_o, e.a);
            check_val("issue_b_o", issue_b_o, e.b);
            check_val("issue_rd_o", issue_rd_o, e.rd);
            check_val("issue_wreg_o", issue_wreg_o, e.wreg);
            check_val("issue_illegal_o", issue_illegal_o, e.illegal);
            check_val("issue_taken_o", issue_taken_o, e.taken);
            check_val("issue_redirect_o", issue_redirect_o, e.redirect);
            check_val("issue_target_o", issue_target_o, e.target);
            issued++;
         end
         if (in_valid_i && in_ready_o)
            exp_q.push_back(expect_issue(in_pc_i, in_inst_i, in_pred_taken_i,
                                         read_shadow(in_inst_i[19:15]),
                                         read_shadow(in_inst_i[24:20])));
         if (wb_en_i && (wb_addr_i != '0))
            shadow[wb_addr_i] = wb_data_i;
      end
   end

   initial
   begin
      lcg_state       = SEED;
      ready_random    = 1'b0;
      sent            = 0;
      issued          = 0;
      rst_i           = 1'b1;
      in_valid_i      = 1'b0;
      in_pc_i         = '0;
      in_inst_i       = '0;
      in_pred_taken_i = 1'b0;
      wb_en_i         = 1'b0;
      wb_addr_i       = '0;
      wb_data_i       = '0;
      issue_ready_i   = 1'b0;
      repeat (16) @(posedge clk);
      rst_i <= 1'b0;
      @(posedge clk);
      check_val("issue_valid_o", issue_valid_o, 1'b0);
      check_val("in_ready_o", in_ready_o, 1'b1);

      run_phase(0, 1, NUM_INST, 1'b0);           // op, op-imm
      run_phase(2, 3, 20, 1'b0);                 // lui, auipc
      run_phase(4, 4, NUM_INST, 1'b0);           // branches
      run_phase(5, 7, 30, 1'b0);                 // jumps and unknown encodings
      run_phase(0, 7, 200, 1'b1);                // mixed with back-pressure

      if (issued == sent)
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
      else
         abort_run($sformatf("issued %0d instructions but accepted %0d", issued, sent));
   end

endmodule

`default_nettype wire

// ==== verilog/branch_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module branch_resolver
(
   input  wire                    head_valid_i,
   input  wire decode_pkg::uop_t  head_i,
   output logic                   pop_o,
   input  wire                    issue_ready_i,
   output logic                   issue_valid_o,
   output logic [`DU_XLEN-1:0]    issue_pc_o,
   output decode_pkg::alu_op_e    issue_op_o,
   output decode_pkg::alu_sel_e   issue_sel_o,
   output logic [`DU_XLEN-1:0]    issue_a_o,
   output logic [`DU_XLEN-1:0]    issue_b_o,
   output logic [`DU_RADDR_W-1:0] issue_rd_o,
   output logic                   issue_wreg_o,
   output logic                   issue_illegal_o,
   output logic                   issue_taken_o,
   output logic                   issue_redirect_o,
   output logic [`DU_XLEN-1:0]    issue_target_o
);
   import decode_pkg::*;

   logic [`DU_XLEN-1:0] link_addr;
   logic [`DU_XLEN-1:0] rel_target;
   logic [`DU_XLEN-1:0] jalr_sum;
   logic                cmp;

   assign pop_o           = head_valid_i && issue_ready_i;
   assign issue_valid_o   = head_valid_i;
   assign issue_pc_o      = head_i.pc;
   assign issue_op_o      = head_i.op;
   assign issue_sel_o     = head_i.sel;
   assign issue_rd_o      = head_i.rd;
   assign issue_wreg_o    = head_i.wreg;
   assign issue_illegal_o = head_i.illegal;

   assign link_addr  = head_i.pc + `DU_PC_STEP;   // also the fall-through
   assign rel_target = head_i.pc + head_i.imm;
   assign jalr_sum   = head_i.a + head_i.imm;

   always_comb
   begin
      case (head_i.op)
         ALU_BEQ:  cmp = (head_i.a == head_i.b);
         ALU_BNE:  cmp = (head_i.a != head_i.b);
         ALU_BLT:  cmp = ($signed(head_i.a) < $signed(head_i.b));
         ALU_BGE:  cmp = ($signed(head_i.a) >= $signed(head_i.b));
         ALU_BLTU: cmp = (head_i.a < head_i.b);
         ALU_BGEU: cmp = (head_i.a >= head_i.b);
         default:  cmp = 1'b0;
      endcase
   end

   always_comb
   begin
      issue_a_o        = head_i.a;
      issue_b_o        = head_i.b;
      issue_taken_o    = 1'b0;
      issue_redirect_o = 1'b0;
      issue_target_o   = '0;
      case (head_i.op)
         ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU:
         begin
            issue_taken_o    = cmp;
            issue_redirect_o = head_valid_i && (cmp != head_i.pred_taken);   // mispredict
            issue_target_o   = cmp ? rel_target : link_addr;
         end
         ALU_JAL, ALU_JALR:
         begin
            issue_taken_o    = 1'b1;
            issue_redirect_o = head_valid_i;                 // stale head never redirects
            issue_a_o        = link_addr;                    // or with 0 gives link
            issue_b_o        = '0;
            issue_target_o   = (head_i.op == ALU_JAL) ? rel_target
                                                      : {jalr_sum[`DU_XLEN-1:1], 1'b0};
         end
         default:
            issue_target_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/decode_defs.svh ====
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define DU_XLEN        32    // data and address width
`define DU_INST_W      32
`define DU_RADDR_W     5
`define DU_NUM_REGS    32

// ------------------------------------------------------------
// buffer and sequencing
// ------------------------------------------------------------
`define DU_FIFO_DEPTH  2     // micro-op slots
`define DU_PC_STEP     4     // next sequential pc

`endif

// ==== verilog/decode_pkg.sv ====
`default_nettype none
`include "decode_defs.svh"

package decode_pkg;

   // major opcodes handled by the decoder
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011
   } opcode_e;

   typedef enum logic [4:0] {
      ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
      ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
      ALU_JAL, ALU_JALR
   } alu_op_e;

   typedef enum logic [2:0] {
      SEL_NOP, SEL_ARITH, SEL_LOGIC, SEL_SHIFT, SEL_JUMP
   } alu_sel_e;

   typedef struct packed {
      logic [`DU_XLEN-1:0]    pc;
      alu_op_e                op;
      alu_sel_e               sel;
      logic [`DU_XLEN-1:0]    a;
      logic [`DU_XLEN-1:0]    b;
      logic [`DU_XLEN-1:0]    imm;      // branch/jump offset or operand imm
      logic [`DU_RADDR_W-1:0] rd;
      logic                   wreg;
      logic                   pred_taken;
      logic                   illegal;
   } uop_t;

endpackage

`default_nettype wire

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module decode_unit
(
   input  wire                    clk,
   input  wire                    rst_i,
   input  wire                    in_valid_i,
   input  wire [`DU_XLEN-1:0]     in_pc_i,
   input  wire [`DU_INST_W-1:0]   in_inst_i,
   input  wire                    in_pred_taken_i,
   output logic                   in_ready_o,
   input  wire                    wb_en_i,
   input  wire [`DU_RADDR_W-1:0]  wb_addr_i,
   input  wire [`DU_XLEN-1:0]     wb_data_i,
   input  wire                    issue_ready_i,
   output logic                   issue_valid_o,
   output logic [`DU_XLEN-1:0]    issue_pc_o,
   output decode_pkg::alu_op_e    issue_op_o,
   output decode_pkg::alu_sel_e   issue_sel_o,
   output logic [`DU_XLEN-1:0]    issue_a_o,
   output logic [`DU_XLEN-1:0]    issue_b_o,
   output logic [`DU_RADDR_W-1:0] issue_rd_o,
   output logic                   issue_wreg_o,
   output logic                   issue_illegal_o,
   output logic                   issue_taken_o,
   output logic                   issue_redirect_o,
   output logic [`DU_XLEN-1:0]    issue_target_o
);
   import decode_pkg::*;

   logic [`DU_RADDR_W-1:0] rs1_addr;
   logic [`DU_RADDR_W-1:0] rs2_addr;
   logic [`DU_XLEN-1:0]    rs1_data;
   logic [`DU_XLEN-1:0]    rs2_data;
   logic                   dec_valid;
   logic                   push;
   logic                   fifo_ready;
   logic                   head_valid;
   logic                   pop;
   uop_t                   dec_uop;
   uop_t                   head;

   assign in_ready_o = fifo_ready;
   assign dec_valid  = in_valid_i && fifo_ready;   // accept handshake

   // ------------------------------------------------------------
   // register file and decode
   // ------------------------------------------------------------
   reg_file u_reg_file
   (
      .clk        (clk),
      .rst_i      (rst_i),
      .wb_en_i    (wb_en_i),
      .wb_addr_i  (wb_addr_i),
      .wb_data_i  (wb_data_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

   inst_decoder u_inst_decoder
   (
      .in_valid_i      (dec_valid),
      .in_pc_i         (in_pc_i),
      .in_inst_i       (in_inst_i),
      .in_pred_taken_i (in_pred_taken_i),
      .rs1_addr_o      (rs1_addr),
      .rs2_addr_o      (rs2_addr),
      .rs1_data_i      (rs1_data),
      .rs2_data_i      (rs2_data),
      .push_o          (push),
      .uop_o           (dec_uop)
   );

   // ------------------------------------------------------------
   // micro-op buffer and issue
   // ------------------------------------------------------------
   uop_fifo #(.DEPTH(`DU_FIFO_DEPTH)) u_uop_fifo
   (
      .clk          (clk),
      .rst_i        (rst_i),
      .push_i       (push),
      .data_i       (dec_uop),
      .ready_o      (fifo_ready),
      .head_valid_o (head_valid),
      .head_o       (head),
      .pop_i        (pop)
   );

   branch_resolver u_branch_resolver
   (
      .head_valid_i     (head_valid),
      .head_i           (head),
      .pop_o            (pop),
      .issue_ready_i    (issue_ready_i),
      .issue_valid_o    (issue_valid_o),
      .issue_pc_o       (issue_pc_o),
      .issue_op_o       (issue_op_o),
      .issue_sel_o      (issue_sel_o),
      .issue_a_o        (issue_a_o),
      .issue_b_o        (issue_b_o),
      .issue_rd_o       (issue_rd_o),
      .issue_wreg_o     (issue_wreg_o),
      .issue_illegal_o  (issue_illegal_o),
      .issue_taken_o    (issue_taken_o),
      .issue_redirect_o (issue_redirect_o),
      .issue_target_o   (issue_target_o)
   );

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module inst_decoder
(
   input  wire                    in_valid_i,
   input  wire [`DU_XLEN-1:0]     in_pc_i,
   input  wire [`DU_INST_W-1:0]   in_inst_i,
   input  wire                    in_pred_taken_i,
   output logic [`DU_RADDR_W-1:0] rs1_addr_o,
   output logic [`DU_RADDR_W-1:0] rs2_addr_o,
   input  wire [`DU_XLEN-1:0]     rs1_data_i,
   input  wire [`DU_XLEN-1:0]     rs2_data_i,
   output logic                   push_o,
   output decode_pkg::uop_t       uop_o
);
   import decode_pkg::*;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub, sra

   logic [2:0]          funct3;
   logic [6:0]          funct7;
   logic [`DU_XLEN-1:0] imm_i;
   logic [`DU_XLEN-1:0] imm_u;
   logic [`DU_XLEN-1:0] imm_b;
   logic [`DU_XLEN-1:0] imm_j;
   logic [`DU_XLEN-1:0] shamt;
   logic [`DU_XLEN-1:0] imm;
   alu_op_e             op;
   logic                rs1_en;
   logic                rs2_en;
   logic                wreg;
   logic                legal;

   function automatic alu_sel_e sel_of(input alu_op_e o);
      case (o)
         ALU_NOP:                            sel_of = SEL_NOP;
         ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: sel_of = SEL_ARITH;
         ALU_XOR, ALU_OR, ALU_AND:           sel_of = SEL_LOGIC;
         ALU_SLL, ALU_SRL, ALU_SRA:          sel_of = SEL_SHIFT;
         default:                            sel_of = SEL_JUMP;
      endcase
   endfunction

   assign funct3     = in_inst_i[14:12];
   assign funct7     = in_inst_i[31:25];
   assign rs1_addr_o = in_inst_i[19:15];
   assign rs2_addr_o = in_inst_i[24:20];
   assign push_o     = in_valid_i;

   assign imm_i = {{20{in_inst_i[31]}}, in_inst_i[31:20]};
   assign imm_u = {in_inst_i[31:12], 12'h0};
   assign imm_b = {{19{in_inst_i[31]}}, in_inst_i[31], in_inst_i[7],
                   in_inst_i[30:25], in_inst_i[11:8], 1'b0};
   assign imm_j = {{11{in_inst_i[31]}}, in_inst_i[31], in_inst_i[19:12],
                   in_inst_i[20], in_inst_i[30:21], 1'b0};
   assign shamt = {27'h0, in_inst_i[24:20]};

   // ------------------------------------------------------------
   // opcode / funct decode
   // ------------------------------------------------------------
   always_comb
   begin
      op     = ALU_NOP;
      rs1_en = 1'b0;
      rs2_en = 1'b0;
      wreg   = 1'b0;
      imm    = '0;
      legal  = 1'b0;
      case (opcode_e'(in_inst_i[6:0]))
         OPC_OP:
         begin
            rs1_en = 1'b1;
            rs2_en = 1'b1;
            wreg   = 1'b1;
            legal  = 1'b1;
            case ({funct7, funct3})
               {F7_BASE, 3'b000}: op = ALU_ADD;
               {F7_ALT,  3'b000}: op = ALU_SUB;
               {F7_BASE, 3'b001}: op = ALU_SLL;
               {F7_BASE, 3'b010}: op = ALU_SLT;
               {F7_BASE, 3'b011}: op = ALU_SLTU;
               {F7_BASE, 3'b100}: op = ALU_XOR;
               {F7_BASE, 3'b101}: op = ALU_SRL;
               {F7_ALT,  3'b101}: op = ALU_SRA;
               {F7_BASE, 3'b110}: op = ALU_OR;
               {F7_BASE, 3'b111}: op = ALU_AND;
               default:           legal = 1'b0;
            endcase
         end
         OPC_OP_IMM:
         begin
            rs1_en = 1'b1;
            wreg   = 1'b1;
            legal  = 1'b1;
            imm    = imm_i;
            case (funct3)
               3'b000: op = ALU_ADD;
               3'b010: op = ALU_SLT;
               3'b011: op = ALU_SLTU;
               3'b100: op = ALU_XOR;
               3'b110: op = ALU_OR;
               3'b111: op = ALU_AND;
               3'b001:
               begin
                  op    = ALU_SLL;
                  imm   = shamt;
                  legal = (funct7 == F7_BASE);
               end
               default:                          // 3'b101, srli / srai
               begin
                  op    = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                  imm   = shamt;
                  legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
               end
            endcase
         end
         OPC_LUI, OPC_AUIPC:
         begin
            op    = ALU_OR;                      // or of two equal operands
            wreg  = 1'b1;
            legal = 1'b1;
            imm   = (in_inst_i[5]) ? imm_u : in_pc_i + imm_u;
         end
         OPC_JAL:
         begin
            op    = ALU_JAL;
            wreg  = 1'b1;
            legal = 1'b1;
            imm   = imm_j;
         end
         OPC_JALR:
         begin
            op     = ALU_JALR;
            rs1_en = 1'b1;
            wreg   = 1'b1;
            legal  = (funct3 == 3'b000);
            imm    = imm_i;
         end
         OPC_BRANCH:
         begin
            rs1_en = 1'b1;
            rs2_en = 1'b1;
            legal  = 1'b1;
            imm    = imm_b;
            case (funct3)
               3'b000:  op = ALU_BEQ;
               3'b001:  op = ALU_BNE;
               3'b100:  op = ALU_BLT;
               3'b101:  op = ALU_BGE;
               3'b110:  op = ALU_BLTU;
               3'b111:  op = ALU_BGEU;
               default: legal = 1'b0;
            endcase
         end
         default:
            legal = 1'b0;
      endcase

      if (!legal)
      begin
         op     = ALU_NOP;
         rs1_en = 1'b0;
         rs2_en = 1'b0;
         wreg   = 1'b0;
         imm    = '0;
      end
   end

   always_comb
   begin
      uop_o.pc         = in_pc_i;
      uop_o.op         = op;
      uop_o.sel        = sel_of(op);
      uop_o.a          = rs1_en ? rs1_data_i : imm;
      uop_o.b          = rs2_en ? rs2_data_i : imm;
      uop_o.imm        = imm;
      uop_o.rd         = in_inst_i[11:7];
      uop_o.wreg       = wreg;
      uop_o.pred_taken = in_pred_taken_i;
      uop_o.illegal    = !legal;
   end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module reg_file
(
   input  wire                    clk,
   input  wire                    rst_i,
   input  wire                    wb_en_i,
   input  wire [`DU_RADDR_W-1:0]  wb_addr_i,
   input  wire [`DU_XLEN-1:0]     wb_data_i,
   input  wire [`DU_RADDR_W-1:0]  rs1_addr_i,
   input  wire [`DU_RADDR_W-1:0]  rs2_addr_i,
   output logic [`DU_XLEN-1:0]    rs1_data_o,
   output logic [`DU_XLEN-1:0]    rs2_data_o
);

   logic [`DU_XLEN-1:0] regs [0:`DU_NUM_REGS-1];

   function automatic logic [`DU_XLEN-1:0] read_port(input logic [`DU_RADDR_W-1:0] addr);
      if (addr == '0)
         read_port = '0;                          // x0
      else if (wb_en_i && (wb_addr_i == addr))
         read_port = wb_data_i;                   // write-through
      else
         read_port = regs[addr];
   endfunction

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         for (int i = 0; i < `DU_NUM_REGS; i++)
            regs[i] <= '0;
      end
      else if (wb_en_i && (wb_addr_i != '0))
      begin
         regs[wb_addr_i] <= wb_data_i;
      end
   end

   always_comb
   begin
      rs1_data_o = read_port(rs1_addr_i);
      rs2_data_o = read_port(rs2_addr_i);
   end

endmodule

`default_nettype wire

// ==== verilog/uop_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module uop_fifo
#(
   parameter int DEPTH = `DU_FIFO_DEPTH
)
(
   input  wire                    clk,
   input  wire                    rst_i,
   input  wire                    push_i,
   input  wire decode_pkg::uop_t  data_i,
   output logic                   ready_o,
   output logic                   head_valid_o,
   output decode_pkg::uop_t       head_o,
   input  wire                    pop_i
);
   import decode_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   uop_t             mem [0:DEPTH-1];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign ready_o      = (count != CNT_W'(DEPTH));   // not full
   assign head_valid_o = (count != '0);
   assign head_o       = mem[rd_ptr];
   assign do_push      = push_i && ready_o;           // push into full is dropped
   assign do_pop       = pop_i && head_valid_o;

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_next(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // idle or push+pop
         endcase
      end
   end

endmodule

`default_nettype wire
